// File: src/csr_pkg.sv
package csr_pkg;

    //////////////////////////////
    // basic types
    //////////////////////////////

    typedef logic [13:0] csr_addr_t;
    typedef logic [31:0] csr_data_t;
    typedef logic [1:0]  plv_t;
    typedef logic [5:0]  ecode_t;
    // [5:0] primary code, [6] secondary code
    typedef logic [6:0]  excp_code_t;
    typedef logic [7:0]  hw_int_t;
    typedef logic [12:0] int_vec_t;

    // software write port
    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        csr_data_t mask;
        csr_data_t data;
    } csr_wr_t;

    // exception events from the pipeline
    typedef struct packed {
        logic       store_state;
        logic       restore_state;
        logic       ecode_we;
        excp_code_t ecode_in;
        logic       era_we;
        csr_data_t  era_in;
        logic       badv_we;
        csr_data_t  badv_in;
    } excp_evt_t;

    //////////////////////////////
    // register addresses
    //////////////////////////////

    localparam csr_addr_t CSR_CRMD   = 14'h000;
    localparam csr_addr_t CSR_PRMD   = 14'h001;
    localparam csr_addr_t CSR_ECFG   = 14'h004;
    localparam csr_addr_t CSR_ESTAT  = 14'h005;
    localparam csr_addr_t CSR_ERA    = 14'h006;
    localparam csr_addr_t CSR_BADV   = 14'h007;
    localparam csr_addr_t CSR_EENTRY = 14'h00C;
    localparam csr_addr_t CSR_SAVE0  = 14'h030;
    localparam csr_addr_t CSR_SAVE1  = 14'h031;
    localparam csr_addr_t CSR_SAVE2  = 14'h032;
    localparam csr_addr_t CSR_SAVE3  = 14'h033;
    localparam csr_addr_t CSR_TCFG   = 14'h041;
    localparam csr_addr_t CSR_TVAL   = 14'h042;
    localparam csr_addr_t CSR_TICLR  = 14'h044;

    // field positions
    localparam int TIMER_IS_BIT    = 11;
    localparam int HW_IS_LSB       = 2;
    localparam int ESTAT_ECODE_LSB = 16;
    localparam int ESTAT_ESUB_LSB  = 22;
    localparam int EENTRY_VA_LSB   = 6;

    // bits with mask set take the new value
    function automatic csr_data_t masked_merge(csr_data_t old_val, csr_data_t new_val,
                                               csr_data_t mask);
        return (old_val & ~mask) | (new_val & mask);
    endfunction

endpackage

// File: src/csr_mode_regs.sv
module csr_mode_regs
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  csr_wr_t    wr,
    input  excp_evt_t  excp,
    output plv_t       plv,
    output logic       ie,
    output logic [1:0] translate_mode,
    output csr_data_t  crmd,
    output csr_data_t  prmd
);

    logic      da, pg;
    plv_t      pplv;
    logic      pie;
    logic      crmd_sel, prmd_sel;
    csr_data_t crmd_wr, prmd_wr;

    assign crmd_sel = wr.en && (wr.addr == CSR_CRMD);
    assign prmd_sel = wr.en && (wr.addr == CSR_PRMD);
    assign crmd_wr  = masked_merge(crmd, wr.data, wr.mask);
    assign prmd_wr  = masked_merge(prmd, wr.data, wr.mask);

    // CRMD: restore, then store, then software
    always_ff @(posedge clk) begin
        if (!rstn) begin
            plv <= '0;
            ie  <= 1'b0;
            da  <= 1'b1;
            pg  <= 1'b0;
        end else if (excp.restore_state) begin
            plv <= pplv;
            ie  <= pie;
        end else if (excp.store_state) begin
            plv <= '0;
            ie  <= 1'b0;
        end else if (crmd_sel) begin
            plv <= crmd_wr[1:0];
            ie  <= crmd_wr[2];
            // pg/da only move to a one-hot pair
            if (crmd_wr[4] ^ crmd_wr[3]) begin
                pg <= crmd_wr[4];
                da <= crmd_wr[3];
            end
        end
    end

    // PRMD: store, then software
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pplv <= '0;
            pie  <= 1'b0;
        end else if (excp.store_state) begin
            pplv <= plv;
            pie  <= ie;
        end else if (prmd_sel) begin
            pplv <= prmd_wr[1:0];
            pie  <= prmd_wr[2];
        end
    end

    assign crmd           = {27'b0, pg, da, ie, plv};
    assign prmd           = {29'b0, pie, pplv};
    assign translate_mode = {pg, da};

endmodule

// File: src/csr_excp_regs.sv
module csr_excp_regs
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  csr_wr_t   wr,
    input  excp_evt_t excp,
    input  logic      ie,
    input  logic      timer_int,
    input  hw_int_t   hardware_int,
    output ecode_t    ecode,
    output csr_data_t era_out,
    output csr_data_t eentry,
    output csr_data_t ecfg,
    output csr_data_t estat,
    output csr_data_t badv,
    output logic      has_interrupt_cpu,
    output logic      has_interrupt_idle
);

    int_vec_t                    lie;
    logic [1:0]                  is_sw;
    logic                        esub;
    logic [31:EENTRY_VA_LSB]     eentry_va;
    int_vec_t                    is_vec;
    csr_data_t                   ecfg_wr, estat_wr, eentry_wr;

    assign ecfg_wr   = masked_merge(ecfg, wr.data, wr.mask);
    assign estat_wr  = masked_merge(estat, wr.data, wr.mask);
    assign eentry_wr = masked_merge(eentry, wr.data, wr.mask);

    //////////////////////////////
    // config, status
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lie <= '0;
        end else if (wr.en && (wr.addr == CSR_ECFG)) begin
            lie <= ecfg_wr[12:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            is_sw <= '0;
            ecode <= '0;
            esub  <= 1'b0;
        end else if (excp.ecode_we) begin
            ecode <= excp.ecode_in[5:0];
            // secondary code only with a nonzero primary
            esub  <= (|excp.ecode_in[5:0]) & excp.ecode_in[6];
        end else if (wr.en && (wr.addr == CSR_ESTAT)) begin
            is_sw <= estat_wr[1:0];
        end
    end

    //////////////////////////////
    // addresses
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            era_out <= '0;
        end else if (excp.era_we) begin
            era_out <= excp.era_in;
        end else if (wr.en && (wr.addr == CSR_ERA)) begin
            era_out <= masked_merge(era_out, wr.data, wr.mask);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            badv <= '0;
        end else if (excp.badv_we) begin
            badv <= excp.badv_in;
        end else if (wr.en && (wr.addr == CSR_BADV)) begin
            badv <= masked_merge(badv, wr.data, wr.mask);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            eentry_va <= '0;
        end else if (wr.en && (wr.addr == CSR_EENTRY)) begin
            eentry_va <= eentry_wr[31:EENTRY_VA_LSB];
        end
    end

    // interrupt status vector
    always_comb begin
        is_vec                     = '0;
        is_vec[1:0]                = is_sw;
        is_vec[HW_IS_LSB +: 8]     = hardware_int;
        is_vec[TIMER_IS_BIT]       = timer_int;
    end

    always_comb begin
        estat                          = '0;
        estat[12:0]                    = is_vec;
        estat[ESTAT_ECODE_LSB +: 6]    = ecode;
        estat[ESTAT_ESUB_LSB]          = esub;
    end

    assign ecfg   = {19'b0, lie};
    assign eentry = {eentry_va, {EENTRY_VA_LSB{1'b0}}};

    assign has_interrupt_idle = |is_vec;
    assign has_interrupt_cpu  = ie & (|(is_vec & lie));

endmodule

// File: src/csr_timer.sv
module csr_timer
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  csr_wr_t   wr,
    output csr_data_t tcfg,
    output csr_data_t tval,
    output logic      timer_int
);

    logic        en;
    logic        periodic;
    logic [29:0] initval;
    logic        reload;
    logic        timeout;
    logic        tcfg_sel;
    logic        ticlr_hit;
    csr_data_t   tcfg_wr;

    assign tcfg_sel  = wr.en && (wr.addr == CSR_TCFG);
    assign ticlr_hit = wr.en && (wr.addr == CSR_TICLR) && wr.mask[0] && wr.data[0];
    assign tcfg_wr   = masked_merge(tcfg, wr.data, wr.mask);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            en       <= 1'b0;
            periodic <= 1'b0;
            initval  <= '0;
            reload   <= 1'b0;
        end else begin
            // any touched bit restarts the count
            reload <= tcfg_sel && (|wr.mask);
            if (tcfg_sel) begin
                en       <= tcfg_wr[0];
                periodic <= tcfg_wr[1];
                initval  <= tcfg_wr[31:2];
            end
        end
    end

    //////////////////////////////
    // countdown
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tval    <= '0;
            timeout <= 1'b0;
        end else if (reload || (tval == '0)) begin
            timeout <= 1'b0;
            // one above initval so a zero setting still fires
            if (reload || periodic) tval <= {initval, 2'b01};
        end else begin
            timeout <= en && (tval == 32'd1);
            if (en) tval <= tval - 32'd1;
        end
    end

    // clear wins over set
    always_ff @(posedge clk) begin
        if (!rstn || ticlr_hit) begin
            timer_int <= 1'b0;
        end else if (timeout) begin
            timer_int <= 1'b1;
        end
    end

    assign tcfg = {initval, periodic, en};

endmodule

// File: src/csr_save_regs.sv
module csr_save_regs
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  csr_wr_t   wr,
    output csr_data_t save0,
    output csr_data_t save1,
    output csr_data_t save2,
    output csr_data_t save3
);

    csr_data_t save_q [4];
    logic      save_sel;
    csr_data_t save_wr;

    // SAVE0..3 share the upper address bits
    assign save_sel = wr.en && (wr.addr[13:2] == CSR_SAVE0[13:2]);
    assign save_wr  = masked_merge(save_q[wr.addr[1:0]], wr.data, wr.mask);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < 4; i++) save_q[i] <= '0;
        end else if (save_sel) begin
            save_q[wr.addr[1:0]] <= save_wr;
        end
    end

    assign save0 = save_q[0];
    assign save1 = save_q[1];
    assign save2 = save_q[2];
    assign save3 = save_q[3];

endmodule

// File: src/csr_read_mux.sv
module csr_read_mux
    import csr_pkg::*;
(
    input  csr_addr_t raddr_a,
    input  csr_addr_t raddr_b,
    input  csr_data_t crmd,
    input  csr_data_t prmd,
    input  csr_data_t ecfg,
    input  csr_data_t estat,
    input  csr_data_t era,
    input  csr_data_t badv,
    input  csr_data_t eentry,
    input  csr_data_t save0,
    input  csr_data_t save1,
    input  csr_data_t save2,
    input  csr_data_t save3,
    input  csr_data_t tcfg,
    input  csr_data_t tval,
    output csr_data_t rdata_a,
    output csr_data_t rdata_b
);

    // one decoder, used by both ports
    function automatic csr_data_t pick(csr_addr_t addr);
        case (addr)
            CSR_CRMD:   return crmd;
            CSR_PRMD:   return prmd;
            CSR_ECFG:   return ecfg;
            CSR_ESTAT:  return estat;
            CSR_ERA:    return era;
            CSR_BADV:   return badv;
            CSR_EENTRY: return eentry;
            CSR_SAVE0:  return save0;
            CSR_SAVE1:  return save1;
            CSR_SAVE2:  return save2;
            CSR_SAVE3:  return save3;
            CSR_TCFG:   return tcfg;
            CSR_TVAL:   return tval;
            CSR_TICLR:  return '0;
            default:    return '0;
        endcase
    endfunction

    always_comb begin
        rdata_a = pick(raddr_a);
        rdata_b = pick(raddr_b);
    end

endmodule

// File: src/csr_top.sv
module csr_top
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  csr_wr_t   wr,
    input  excp_evt_t excp,
    input  csr_addr_t raddr_a,
    input  csr_addr_t raddr_b,
    input  hw_int_t   hardware_int,
    output csr_data_t rdata_a,
    output csr_data_t rdata_b,
    output plv_t      plv,
    output ecode_t    ecode,
    output csr_data_t era_out,
    output csr_data_t eentry,
    output logic [1:0] translate_mode,
    output logic      has_interrupt_cpu,
    output logic      has_interrupt_idle
);

    logic      ie;
    logic      timer_int;
    csr_data_t crmd, prmd;
    csr_data_t ecfg, estat, badv;
    csr_data_t tcfg, tval;
    csr_data_t save0, save1, save2, save3;

    csr_mode_regs u_mode (
        .clk            (clk),
        .rstn           (rstn),
        .wr             (wr),
        .excp           (excp),
        .plv            (plv),
        .ie             (ie),
        .translate_mode (translate_mode),
        .crmd           (crmd),
        .prmd           (prmd)
    );

    csr_excp_regs u_excp (
        .clk                (clk),
        .rstn               (rstn),
        .wr                 (wr),
        .excp               (excp),
        .ie                 (ie),
        .timer_int          (timer_int),
        .hardware_int       (hardware_int),
        .ecode              (ecode),
        .era_out            (era_out),
        .eentry             (eentry),
        .ecfg               (ecfg),
        .estat              (estat),
        .badv               (badv),
        .has_interrupt_cpu  (has_interrupt_cpu),
        .has_interrupt_idle (has_interrupt_idle)
    );

    csr_timer u_timer (
        .clk       (clk),
        .rstn      (rstn),
        .wr        (wr),
        .tcfg      (tcfg),
        .tval      (tval),
        .timer_int (timer_int)
    );

    csr_save_regs u_save (
        .clk   (clk),
        .rstn  (rstn),
        .wr    (wr),
        .save0 (save0),
        .save1 (save1),
        .save2 (save2),
        .save3 (save3)
    );

    csr_read_mux u_rmux (
        .raddr_a (raddr_a), .raddr_b (raddr_b),
        .crmd    (crmd),    .prmd    (prmd),
        .ecfg    (ecfg),    .estat   (estat),
        .era     (era_out), .badv    (badv),
        .eentry  (eentry),
        .save0   (save0),   .save1   (save1),
        .save2   (save2),   .save3   (save3),
        .tcfg    (tcfg),    .tval    (tval),
        .rdata_a (rdata_a), .rdata_b (rdata_b)
    );

endmodule

// File: dv/csr_tb.sv
module csr_tb
    import csr_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic       clk = 1'b0;
    logic       rstn;
    csr_wr_t    wr;
    excp_evt_t  excp;
    csr_addr_t  raddr_a, raddr_b;
    hw_int_t    hardware_int;
    csr_data_t  rdata_a, rdata_b;
    plv_t       plv;
    ecode_t     ecode;
    csr_data_t  era_out, eentry;
    logic [1:0] translate_mode;
    logic       has_interrupt_cpu, has_interrupt_idle;

    int          checks = 0;
    int          errors = 0;
    logic [31:0] seed = 32'h5550_b502;
    // expected register words, missing keys read 0
    csr_data_t   model [csr_addr_t];

    csr_top uut (.*);

    always #10 clk = ~clk;

    //////////////////////////////
    // properties
    //////////////////////////////

    // pg/da never leaves a one-hot pair
    assert property (@(posedge clk) disable iff (!rstn) translate_mode inside {2'b01, 2'b10})
    else begin
        $display("Fail %0t translate_mode exp=01|10 act=%b", $time, translate_mode);
        errors++;
    end

    // any raised hardware line shows up as a pending interrupt
    assert property (@(posedge clk) disable iff (!rstn) (|hardware_int) |-> has_interrupt_idle)
    else begin
        $display("Fail %0t has_interrupt_idle exp=1 act=%b", $time, has_interrupt_idle);
        errors++;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic logic [31:0] xorshift(logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] next_rand();
        seed = xorshift(seed);
        return seed;
    endfunction

    // writable bits of the plainly modelled registers
    function automatic csr_data_t impl_bits(csr_addr_t a);
        case (a)
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_ERA, CSR_BADV: return '1;
            CSR_EENTRY: return 32'hffff_ffc0;
            CSR_ECFG:   return 32'h0000_1fff;
            default:    return '0;
        endcase
    endfunction

    function automatic csr_data_t exp_of(csr_addr_t a);
        return model.exists(a) ? model[a] : '0;
    endfunction

    task automatic check(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("Fail %0t %s exp=%h act=%h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic note_error(string msg);
        errors++;
        $display("%0t %s", $time, msg);
    endtask

    // starts and ends on a falling edge
    task automatic apply(csr_wr_t w, excp_evt_t e);
        wr   = w;
        excp = e;
        @(posedge clk);
        @(negedge clk);
        wr   = '0;
        excp = '0;
    endtask

    task automatic write_csr(csr_addr_t a, csr_data_t m, csr_data_t d);
        csr_wr_t w;
        w = '{en: 1'b1, addr: a, mask: m, data: d};
        if (|impl_bits(a))
            model[a] = ((exp_of(a) & ~m) | (d & m)) & impl_bits(a);
        apply(w, '0);
    endtask

    task automatic read_pair(csr_addr_t a, csr_addr_t b);
        raddr_a = a;
        raddr_b = b;
        #1;
        check($sformatf("rdata_a[%h]", a), exp_of(a), rdata_a);
        check($sformatf("rdata_b[%h]", b), exp_of(b), rdata_b);
        @(negedge clk);
    endtask

    // bounded wait for the timer bit in ESTAT
    task automatic wait_timer_irq(int limit, output bit seen);
        seen    = 1'b0;
        raddr_a = CSR_ESTAT;
        for (int i = 0; i < limit && !seen; i++) begin
            @(negedge clk);
            seen = rdata_a[TIMER_IS_BIT];
        end
    endtask

    task automatic report(string name, int errs_before);
        $display("test %-10s %s", name, (errors == errs_before) ? "ok" : "FAILED");
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    initial begin
        csr_addr_t reset_addrs [17];
        csr_addr_t rw_addrs [8];
        csr_addr_t a;
        csr_wr_t   w;
        excp_evt_t evt;
        csr_data_t d, m, init;
        int        e0;
        bit        seen;

        rstn         = 1'b0;
        wr           = '0;
        excp         = '0;
        raddr_a      = '0;
        raddr_b      = '0;
        hardware_int = '0;
        model[CSR_CRMD] = 32'h8;
        repeat (5) @(negedge clk);
        rstn = 1'b1;

        e0 = errors;
        reset_addrs = '{CSR_CRMD, CSR_PRMD, CSR_ECFG, CSR_ESTAT, CSR_ERA, CSR_BADV, CSR_EENTRY,
                        CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_TCFG, CSR_TVAL,
                        CSR_TICLR, 14'h002, 14'h100, 14'h3fff};
        foreach (reset_addrs[i])
            read_pair(reset_addrs[i], reset_addrs[(i + 5) % 17]);
        check("translate_mode", 32'h1, 32'(translate_mode));
        check("has_interrupt_cpu", 32'h0, 32'(has_interrupt_cpu));
        check("has_interrupt_idle", 32'h0, 32'(has_interrupt_idle));
        check("plv", 32'h0, 32'(plv));
        report("reset", e0);

        e0 = errors;
        rw_addrs = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3,
                     CSR_ERA, CSR_BADV, CSR_EENTRY, CSR_ECFG};
        for (int n = 0; n < 24; n++) begin
            a = rw_addrs[next_rand() & 32'h7];
            m = next_rand();
            d = next_rand();
            write_csr(a, m, d);
            read_pair(a, rw_addrs[n % 8]);
        end
        check("era_out", exp_of(CSR_ERA), era_out);
        check("eentry", exp_of(CSR_EENTRY), eentry);
        // 11 and 00 are refused, 10 is taken
        write_csr(CSR_CRMD, 32'h18, 32'h18);
        check("translate_mode", 32'h1, 32'(translate_mode));
        write_csr(CSR_CRMD, 32'h18, 32'h00);
        check("translate_mode", 32'h1, 32'(translate_mode));
        write_csr(CSR_CRMD, 32'h18, 32'h10);
        check("translate_mode", 32'h2, 32'(translate_mode));
        write_csr(CSR_CRMD, 32'h18, 32'h08);
        check("translate_mode", 32'h1, 32'(translate_mode));
        read_pair(CSR_CRMD, CSR_PRMD);
        report("masked", e0);

        e0 = errors;
        write_csr(CSR_CRMD, 32'h7, 32'h7);
        check("plv", 32'h3, 32'(plv));
        evt = '0;
        evt.store_state = 1'b1;
        apply('0, evt);
        model[CSR_CRMD] = 32'h8;
        model[CSR_PRMD] = 32'h7;
        read_pair(CSR_CRMD, CSR_PRMD);
        check("plv", 32'h0, 32'(plv));
        evt = '0;
        evt.restore_state = 1'b1;
        apply('0, evt);
        model[CSR_CRMD] = 32'hf;
        read_pair(CSR_CRMD, CSR_PRMD);
        check("plv", 32'h3, 32'(plv));
        evt = '0;
        evt.ecode_we = 1'b1;
        evt.ecode_in = 7'h4a;
        apply('0, evt);
        model[CSR_ESTAT] = (32'h0a << ESTAT_ECODE_LSB) | (32'h1 << ESTAT_ESUB_LSB);
        read_pair(CSR_ESTAT, CSR_CRMD);
        check("ecode", 32'h0a, 32'(ecode));
        // zero primary drops the secondary code
        evt.ecode_in = 7'h40;
        apply('0, evt);
        model[CSR_ESTAT] = 32'h0;
        read_pair(CSR_ESTAT, CSR_PRMD);
        check("ecode", 32'h0, 32'(ecode));
        d   = next_rand();
        evt = '0;
        evt.era_we  = 1'b1;
        evt.era_in  = d;
        evt.badv_we = 1'b1;
        evt.badv_in = ~d;
        w = '{en: 1'b1, addr: CSR_ERA, mask: '1, data: next_rand()};
        apply(w, evt);
        w.addr = CSR_BADV;
        evt.era_we = 1'b0;
        apply(w, evt);
        model[CSR_ERA]  = d;
        model[CSR_BADV] = ~d;
        read_pair(CSR_ERA, CSR_BADV);
        check("era_out", d, era_out);
        check("eentry", exp_of(CSR_EENTRY), eentry);
        report("exception", e0);

        e0 = errors;
        write_csr(CSR_ECFG, '1, 32'h0);
        hardware_int = 8'h24;
        model[CSR_ESTAT] = 32'h24 << HW_IS_LSB;
        read_pair(CSR_ESTAT, CSR_ECFG);
        check("has_interrupt_idle", 32'h1, 32'(has_interrupt_idle));
        check("has_interrupt_cpu", 32'h0, 32'(has_interrupt_cpu));
        // hw line 2 sits at status bit 4
        write_csr(CSR_ECFG, '1, 32'h1 << (HW_IS_LSB + 2));
        check("has_interrupt_cpu", 32'h1, 32'(has_interrupt_cpu));
        write_csr(CSR_CRMD, 32'h4, 32'h0);
        check("has_interrupt_cpu", 32'h0, 32'(has_interrupt_cpu));
        write_csr(CSR_CRMD, 32'h4, 32'h4);
        write_csr(CSR_ECFG, '1, 32'h1 << (HW_IS_LSB + 1));
        check("has_interrupt_cpu", 32'h0, 32'(has_interrupt_cpu));
        hardware_int = 8'h00;
        write_csr(CSR_ESTAT, 32'h3, 32'h2);
        model[CSR_ESTAT] = 32'h2;
        read_pair(CSR_ESTAT, CSR_ECFG);
        check("has_interrupt_idle", 32'h1, 32'(has_interrupt_idle));
        check("has_interrupt_cpu", 32'h0, 32'(has_interrupt_cpu));
        write_csr(CSR_ECFG, '1, 32'h2);
        check("has_interrupt_cpu", 32'h1, 32'(has_interrupt_cpu));
        write_csr(CSR_ESTAT, 32'h3, 32'h0);
        model[CSR_ESTAT] = 32'h0;
        read_pair(CSR_ESTAT, CSR_ECFG);
        check("has_interrupt_idle", 32'h0, 32'(has_interrupt_idle));
        report("interrupt", e0);

        e0 = errors;
        write_csr(CSR_ECFG, '1, 32'h1 << TIMER_IS_BIT);
        init = (next_rand() & 32'h7) + 32'h2;
        write_csr(CSR_TCFG, '1, (init << 2) | 32'h1);
        model[CSR_TCFG] = (init << 2) | 32'h1;
        // count loads one edge after the reload pulse
        @(negedge clk);
        model[CSR_TVAL] = (init << 2) | 32'h1;
        read_pair(CSR_TVAL, CSR_TCFG);
        model[CSR_TVAL] = model[CSR_TVAL] - 32'h1;
        read_pair(CSR_TVAL, CSR_TICLR);
        wait_timer_irq(64, seen);
        if (!seen)
            note_error("one-shot timer interrupt never arrived");
        check("has_interrupt_cpu", 32'h1, 32'(has_interrupt_cpu));
        repeat (3) @(negedge clk);
        model[CSR_TVAL]  = 32'h0;
        model[CSR_ESTAT] = 32'h1 << TIMER_IS_BIT;
        read_pair(CSR_TVAL, CSR_ESTAT);
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        model[CSR_ESTAT] = 32'h0;
        read_pair(CSR_ESTAT, CSR_TICLR);
        wait_timer_irq(40, seen);
        if (seen)
            note_error("one-shot timer fired a second time");
        read_pair(CSR_TVAL, CSR_ESTAT);
        write_csr(CSR_TCFG, '1, (init << 2) | 32'h3);
        wait_timer_irq(64, seen);
        if (!seen)
            note_error("periodic timer interrupt never arrived");
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        read_pair(CSR_ESTAT, CSR_TICLR);
        wait_timer_irq(64, seen);
        if (!seen)
            note_error("periodic timer interrupt did not come back after the clear");
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        write_csr(CSR_TCFG, '1, 32'h0);
        report("timer", e0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: sources.f
src/csr_pkg.sv
src/csr_mode_regs.sv
src/csr_excp_regs.sv
src/csr_timer.sv
src/csr_save_regs.sv
src/csr_read_mux.sv
src/csr_top.sv
dv/csr_tb.sv

// File: run.sh
#!/bin/sh
# build and run the CSR testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sources.f --top-module csr_tb -o csr_sim \
    && ./obj_dir/csr_sim | tee /dev/stderr \
        | grep -F "Simulation completed successfully" > /dev/null \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }
